/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address width
`define DATA_W 16

// General purpose registers
`define REG_CNT 8

// First instruction address
`define RESET_PC 16'h0000

// Stack grows down from here
`define STACK_TOP 16'h0FFF

`endif

/* isaPkg.sv */
`default_nettype none

`include "cpu_config.svh"

package isaPkg;

  typedef logic [`DATA_W-1:0] word_t;
  typedef logic [$clog2(`REG_CNT)-1:0] regIdx_t;

  // Interrupt and RTI codes are absent and decode as NOP
  typedef enum logic [4:0] {
    NOP  = 5'b00000,
    SETC = 5'b00001,
    CLRC = 5'b00010,
    NOT  = 5'b00011,
    INC  = 5'b00100,
    DEC  = 5'b00101,
    OUT  = 5'b00110,
    IN   = 5'b00111,
    MOV  = 5'b01000,
    ADD  = 5'b01001,
    SUB  = 5'b01010,
    AND  = 5'b01011,
    OR   = 5'b01100,
    SHL  = 5'b01101,
    SHR  = 5'b01110,
    PUSH = 5'b01111,
    POP  = 5'b10000,
    LDM  = 5'b10001,
    LDD  = 5'b10010,
    STD  = 5'b10011,
    JZ   = 5'b10100,
    JN   = 5'b10101,
    JC   = 5'b10110,
    JMP  = 5'b10111,
    CALL = 5'b11000,
    RET  = 5'b11010
  } opCode_t;

  typedef enum logic [3:0] {
    aluAdd   = 4'b0000,
    aluSub   = 4'b0001,
    aluAnd   = 4'b0010,
    aluOr    = 4'b0011,
    aluShl   = 4'b0100,
    aluShr   = 4'b0101,
    aluNot   = 4'b0110,
    aluPassA = 4'b0111,
    aluInc   = 4'b1000,
    aluDec   = 4'b1001,
    aluPassB = 4'b1010
  } aluOp_t;

  typedef enum logic [1:0] {
    spHold = 2'b00,
    spPush = 2'b01,
    spPop  = 2'b10
  } spOp_t;

  typedef enum logic [1:0] {
    carryKeep  = 2'b00,
    carryClear = 2'b01,
    carrySet   = 2'b11
  } carryOp_t;

  typedef enum logic [1:0] {
    condZero,
    condNeg,
    condCarry,
    condAlways
  } branchCond_t;

  typedef struct packed {
    aluOp_t      aluOp;
    spOp_t       spOp;
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    // Low selects the memory read data for writeback
    logic        memOrReg;
    logic        updateStatus;
    // Low selects the second instruction word for writeback
    logic        immOrReg;
    logic        spOrAluRes;
    logic        branch;
    branchCond_t branchCond;
    carryOp_t    carryOp;
    logic        twoWord;
    logic        outWrite;
    logic        inRead;
    logic        pushPc;
    logic        popPc;
  } ctrl_t;

endpackage

`default_nettype wire

/* busPkg.sv */
`default_nettype none

package busPkg;

  // Master request held steady until ack
  typedef struct packed {
    logic          cyc;
    logic          stb;
    logic          we;
    isaPkg::word_t adr;
    isaPkg::word_t dat;
  } wbReq_t;

  // Slave response
  typedef struct packed {
    logic          ack;
    isaPkg::word_t dat;
  } wbRsp_t;

endpackage

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
  input  isaPkg::opCode_t opCode,
  output isaPkg::ctrl_t   ctrl
);
  import isaPkg::*;

  always_comb begin
    ctrl            = '0;
    ctrl.aluOp      = aluPassA;
    ctrl.immOrReg   = 1'b1;
    ctrl.memOrReg   = 1'b1;
    ctrl.branchCond = condAlways;
    case (opCode)
      SETC: begin
        ctrl.updateStatus = 1'b1;
        ctrl.carryOp      = carrySet;
      end
      CLRC: begin
        ctrl.updateStatus = 1'b1;
        ctrl.carryOp      = carryClear;
      end
      NOT, INC, DEC, ADD, SUB, AND, OR, SHL, SHR: begin
        ctrl.regWrite     = 1'b1;
        ctrl.updateStatus = 1'b1;
        case (opCode)
          NOT:     ctrl.aluOp = aluNot;
          INC:     ctrl.aluOp = aluInc;
          DEC:     ctrl.aluOp = aluDec;
          ADD:     ctrl.aluOp = aluAdd;
          SUB:     ctrl.aluOp = aluSub;
          AND:     ctrl.aluOp = aluAnd;
          OR:      ctrl.aluOp = aluOr;
          SHL:     ctrl.aluOp = aluShl;
          default: ctrl.aluOp = aluShr;
        endcase
      end
      OUT: begin
        ctrl.outWrite = 1'b1;
      end
      IN: begin
        ctrl.aluOp    = aluPassB;
        ctrl.inRead   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      MOV: begin
        ctrl.aluOp    = aluPassB;
        ctrl.regWrite = 1'b1;
      end
      PUSH: begin
        ctrl.memWrite = 1'b1;
        ctrl.spOp     = spPush;
      end
      POP: begin
        ctrl.memRead  = 1'b1;
        ctrl.spOp     = spPop;
        ctrl.regWrite = 1'b1;
        ctrl.memOrReg = 1'b0;
      end
      LDM: begin
        ctrl.regWrite = 1'b1;
        ctrl.immOrReg = 1'b0;
        ctrl.twoWord  = 1'b1;
      end
      // Address comes from Rsrc through the ALU
      LDD: begin
        ctrl.aluOp      = aluPassB;
        ctrl.memRead    = 1'b1;
        ctrl.spOrAluRes = 1'b1;
        ctrl.regWrite   = 1'b1;
        ctrl.memOrReg   = 1'b0;
      end
      STD: begin
        ctrl.aluOp      = aluPassB;
        ctrl.memWrite   = 1'b1;
        ctrl.spOrAluRes = 1'b1;
      end
      JZ, JN, JC, JMP: begin
        ctrl.branch = 1'b1;
        case (opCode)
          JZ:      ctrl.branchCond = condZero;
          JN:      ctrl.branchCond = condNeg;
          JC:      ctrl.branchCond = condCarry;
          default: ctrl.branchCond = condAlways;
        endcase
      end
      CALL: begin
        ctrl.memWrite = 1'b1;
        ctrl.spOp     = spPush;
        ctrl.pushPc   = 1'b1;
        ctrl.branch   = 1'b1;
      end
      RET: begin
        ctrl.memRead = 1'b1;
        ctrl.spOp    = spPop;
        ctrl.popPc   = 1'b1;
        ctrl.branch  = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Table sanity over every opcode
  always_comb begin
    assert (!(ctrl.memRead && ctrl.memWrite))
      else $error("opcode %s reads and writes memory", opCode.name());
    assert (!ctrl.twoWord || ctrl.regWrite || ctrl.branch)
      else $error("two-word opcode %s has no destination", opCode.name());
  end

endmodule

`default_nettype wire

/* sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module sequencer (
  input  logic           clk,
  input  logic           rst,
  output isaPkg::word_t  instr,
  input  isaPkg::ctrl_t  ctrl,
  input  logic           flagsOk,
  input  isaPkg::word_t  pc,
  input  isaPkg::word_t  sp,
  input  isaPkg::word_t  aluRes,
  input  isaPkg::word_t  rdstVal,
  output busPkg::wbReq_t wbOut,
  input  busPkg::wbRsp_t wbIn,
  output logic           pcInc,
  output logic           pcLoad,
  output logic           spStep,
  output isaPkg::word_t  pcLoadVal,
  output logic           regWe,
  output logic           flagWe,
  output logic           outStrobe,
  output isaPkg::word_t  wrData
);
  import isaPkg::*;

  typedef enum logic [2:0] {Fetch, Decode, Imm, Exec, Mem, Write} state_t;

  state_t state;
  word_t  immReg;
  word_t  memData;
  word_t  reqAdr;
  logic   reqWe;
  logic   busState;
  logic   ackSeen;

  assign busState = (state == Fetch) || (state == Imm) || (state == Mem);
  assign ackSeen  = busState && wbOut.cyc && wbIn.ack;

  // Fetch and Imm read at PC, Mem picks SP or the ALU address
  always_comb begin
    reqAdr = pc;
    reqWe  = 1'b0;
    if (state == Mem) begin
      reqAdr = ctrl.spOrAluRes ? aluRes : sp;
      reqWe  = ctrl.memWrite;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= Fetch;
    end else begin
      case (state)
        Fetch:   state <= ackSeen ? Decode : Fetch;
        Decode:  state <= ctrl.twoWord ? Imm : Exec;
        Imm:     state <= ackSeen ? Exec : Imm;
        Exec:    state <= (ctrl.memRead || ctrl.memWrite) ? Mem : Write;
        Mem:     state <= ackSeen ? Write : Mem;
        default: state <= Fetch;
      endcase
    end
  end

  // One cycle idle on entry, then hold the request until ack
  always_ff @(posedge clk) begin
    if (rst) begin
      wbOut <= '0;
    end else if (busState && !wbOut.cyc) begin
      wbOut.cyc <= 1'b1;
      wbOut.stb <= 1'b1;
      wbOut.we  <= reqWe;
      wbOut.adr <= reqAdr;
      wbOut.dat <= ctrl.pushPc ? pc : rdstVal;
    end else if (ackSeen) begin
      wbOut.cyc <= 1'b0;
      wbOut.stb <= 1'b0;
      wbOut.we  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ackSeen) begin
      case (state)
        Fetch:   instr <= wbIn.dat;
        Imm:     immReg <= wbIn.dat;
        default: memData <= wbIn.dat;
      endcase
    end
  end

  assign pcInc     = ackSeen && (state != Mem);
  assign pcLoad    = (state == Write) && ctrl.branch && flagsOk;
  assign pcLoadVal = ctrl.popPc ? memData : rdstVal;
  // Pop steps before the read, push after the write
  assign spStep    = ((state == Exec) && (ctrl.spOp == spPop)) ||
                     ((state == Write) && (ctrl.spOp == spPush));
  assign regWe     = (state == Write) && ctrl.regWrite;
  assign flagWe    = (state == Write) && ctrl.updateStatus;
  assign outStrobe = (state == Write) && ctrl.outWrite;
  assign wrData    = !ctrl.memOrReg ? memData : (ctrl.immOrReg ? aluRes : immReg);

  assert property (@(posedge clk) disable iff (rst) wbOut.stb |-> wbOut.cyc);

  // Classic cycle holds the whole request while waiting
  assert property (@(posedge clk) disable iff (rst)
    (wbOut.cyc && !wbIn.ack) |=> $stable(wbOut));

endmodule

`default_nettype wire

/* addrCounters.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module addrCounters (
  input  logic           clk,
  input  logic           rst,
  input  logic           pcInc,
  input  logic           pcLoad,
  input  logic           spStep,
  input  isaPkg::spOp_t  spOp,
  input  isaPkg::word_t  pcLoadVal,
  output isaPkg::word_t  pc,
  output isaPkg::word_t  sp
);
  import isaPkg::*;

  // Jump target wins over the fetch increment
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (pcLoad) begin
      pc <= pcLoadVal;
    end else if (pcInc) begin
      pc <= pc + 1'b1;
    end
  end

  // SP points at the next free slot
  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= `STACK_TOP;
    end else if (spStep) begin
      if (spOp == spPush) begin
        sp <= sp - 1'b1;
      end else if (spOp == spPop) begin
        sp <= sp + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module regFile (
  input  logic            clk,
  input  logic            rst,
  input  isaPkg::regIdx_t raddrA,
  input  isaPkg::regIdx_t raddrB,
  input  isaPkg::regIdx_t waddr,
  input  logic            we,
  input  isaPkg::word_t   wdata,
  output isaPkg::word_t   rdataA,
  output isaPkg::word_t   rdataB
);
  import isaPkg::*;

  word_t regs [`REG_CNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdataA = regs[raddrA];
  assign rdataB = regs[raddrB];

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module alu (
  input  logic                clk,
  input  logic                rst,
  input  isaPkg::aluOp_t      op,
  input  isaPkg::word_t       a,
  input  isaPkg::word_t       b,
  input  logic [4:0]          shamt,
  input  logic                flagWe,
  input  isaPkg::carryOp_t    carryOp,
  input  isaPkg::branchCond_t cond,
  output isaPkg::word_t       res,
  output logic                condTrue
);
  import isaPkg::*;

  logic [`DATA_W:0] wideRes;
  logic [`DATA_W:0] shrWide;
  logic             carryValid;
  logic             zeroF;
  logic             negF;
  logic             carryF;

  // Top bit of wideRes is the carry or borrow out
  always_comb begin
    shrWide    = {a, 1'b0} >> shamt;
    carryValid = 1'b1;
    case (op)
      aluAdd:  wideRes = {1'b0, a} + {1'b0, b};
      aluSub:  wideRes = {1'b0, a} - {1'b0, b};
      aluInc:  wideRes = {1'b0, a} + {{`DATA_W{1'b0}}, 1'b1};
      aluDec:  wideRes = {1'b0, a} - {{`DATA_W{1'b0}}, 1'b1};
      aluShl:  wideRes = {1'b0, a} << shamt;
      // Last bit shifted out lands in the carry
      aluShr:  wideRes = {shrWide[0], shrWide[`DATA_W:1]};
      default: begin
        carryValid = 1'b0;
        case (op)
          aluAnd:   wideRes = {1'b0, a & b};
          aluOr:    wideRes = {1'b0, a | b};
          aluNot:   wideRes = {1'b0, ~a};
          aluPassB: wideRes = {1'b0, b};
          default:  wideRes = {1'b0, a};
        endcase
      end
    endcase
  end

  assign res = wideRes[`DATA_W-1:0];

  // SETC and CLRC touch only the carry
  always_ff @(posedge clk) begin
    if (rst) begin
      zeroF  <= 1'b0;
      negF   <= 1'b0;
      carryF <= 1'b0;
    end else if (flagWe) begin
      if (carryOp == carryKeep) begin
        zeroF <= (res == '0);
        negF  <= res[`DATA_W-1];
        if (carryValid) begin
          carryF <= wideRes[`DATA_W];
        end
      end else begin
        carryF <= (carryOp == carrySet);
      end
    end
  end

  always_comb begin
    case (cond)
      condZero:  condTrue = zeroF;
      condNeg:   condTrue = negF;
      condCarry: condTrue = carryF;
      default:   condTrue = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* cpuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTop (
  input  logic           clk,
  input  logic           rst,
  output busPkg::wbReq_t wbOut,
  input  busPkg::wbRsp_t wbIn,
  input  isaPkg::word_t  inPort,
  output isaPkg::word_t  outPort,
  output logic           outStrobe
);
  import isaPkg::*;

  word_t instr;
  word_t pc;
  word_t sp;
  word_t aluRes;
  word_t aluB;
  word_t rdataA;
  word_t rdataB;
  word_t pcLoadVal;
  word_t wrData;
  ctrl_t ctrl;
  logic  flagsOk;
  logic  pcInc;
  logic  pcLoad;
  logic  spStep;
  logic  regWe;
  logic  flagWe;

  // IN routes the input port through the ALU B side
  assign aluB = ctrl.inRead ? inPort : rdataB;

  controlUnit i_ctrl (.opCode(opCode_t'(instr[15:11])), .ctrl(ctrl));

  sequencer i_seq (
    .clk(clk), .rst(rst), .instr(instr), .ctrl(ctrl), .flagsOk(flagsOk),
    .pc(pc), .sp(sp), .aluRes(aluRes), .rdstVal(rdataA),
    .wbOut(wbOut), .wbIn(wbIn), .pcInc(pcInc), .pcLoad(pcLoad), .spStep(spStep),
    .pcLoadVal(pcLoadVal), .regWe(regWe), .flagWe(flagWe),
    .outStrobe(outStrobe), .wrData(wrData)
  );

  addrCounters i_addr (
    .clk(clk), .rst(rst), .pcInc(pcInc), .pcLoad(pcLoad), .spStep(spStep),
    .spOp(ctrl.spOp), .pcLoadVal(pcLoadVal), .pc(pc), .sp(sp)
  );

  regFile i_regs (
    .clk(clk), .rst(rst), .raddrA(instr[10:8]), .raddrB(instr[7:5]),
    .waddr(instr[10:8]), .we(regWe), .wdata(wrData),
    .rdataA(rdataA), .rdataB(rdataB)
  );

  alu i_alu (
    .clk(clk), .rst(rst), .op(ctrl.aluOp), .a(rdataA), .b(aluB),
    .shamt(instr[4:0]), .flagWe(flagWe), .carryOp(ctrl.carryOp),
    .cond(ctrl.branchCond), .res(aluRes), .condTrue(flagsOk)
  );

  always_ff @(posedge clk) begin
    if (outStrobe) begin
      outPort <= wrData;
    end
  end

endmodule

`default_nettype wire

/* tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_config.svh"

module tb;
  import isaPkg::*;
  import busPkg::*;

  localparam int    memWords  = 4096;
  localparam int    waitLimit = 2000;
  localparam word_t subAddr   = 16'h0040;
  localparam word_t stackTop  = `STACK_TOP;
  localparam word_t notTaken  = 16'h1111;
  localparam word_t taken     = 16'h2222;

  typedef struct packed {
    opCode_t op;
    // Flag setting op ahead of a branch
    opCode_t pre;
    word_t   a;
    word_t   b;
    word_t   expected;
  } row_t;

  logic   clk;
  logic   rst;
  wbReq_t wbOut;
  wbRsp_t wbIn;
  word_t  inPort;
  word_t  outPort;
  logic   outStrobe;

  word_t       mem [memWords];
  row_t        rows [$];
  int          wp;
  int          errors;
  int          waitLeft;
  logic        busy;
  logic [31:0] lfsr;
  word_t       lastWrAdr;

  cpuTop i_dut (
    .clk(clk), .rst(rst), .wbOut(wbOut), .wbIn(wbIn),
    .inPort(inPort), .outPort(outPort), .outStrobe(outStrobe)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'hA300_0000;
    end
    return n;
  endfunction

  // Wishbone slave acking after 0 to 3 wait cycles
  always begin
    @(posedge clk);
    #2;
    if (wbIn.ack) begin
      wbIn.ack = 1'b0;
    end else if (wbOut.cyc !== 1'b1 || wbOut.stb !== 1'b1) begin
      busy = 1'b0;
    end else begin
      if (!busy) begin
        busy = 1'b1;
        waitLeft = 0;
        for (int i = 0; i < 2; i++) begin
          lfsr = lfsrNext(lfsr);
          waitLeft = waitLeft * 2 + int'(lfsr[0]);
        end
      end
      if (waitLeft > 0) begin
        waitLeft--;
      end else begin
        busy = 1'b0;
        if (wbOut.adr[15:12] != 4'h0) begin
          $display("bus access outside memory at address %h", wbOut.adr);
          errors++;
        end else if (wbOut.we) begin
          mem[wbOut.adr[11:0]] = wbOut.dat;
          lastWrAdr = wbOut.adr;
        end else begin
          wbIn.dat = mem[wbOut.adr[11:0]];
        end
        wbIn.ack = 1'b1;
      end
    end
  end

  function automatic word_t enc(input opCode_t op, input int rd, input int rs, input int imm);
    return {op, rd[2:0], rs[2:0], imm[4:0]};
  endfunction

  task automatic emit(input word_t w);
    mem[wp] = w;
    wp++;
  endtask

  task automatic emitLdm(input int rd, input word_t value);
    emit(enc(LDM, rd, 0, 0));
    emit(value);
  endtask

  // Jump to self through r7
  task automatic emitHalt();
    emitLdm(7, word_t'(wp));
    emit(enc(JMP, 7, 0, 0));
  endtask

  task automatic addRow(input opCode_t op, input opCode_t pre, input word_t a,
                        input word_t b, input word_t expected);
    row_t r;
    r.op = op;
    r.pre = pre;
    r.a = a;
    r.b = b;
    r.expected = expected;
    rows.push_back(r);
  endtask

  task automatic checkValue(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic loadProgram(input row_t r);
    int shamt;
    shamt = (r.op == SHL || r.op == SHR) ? int'(r.b[4:0]) : 0;
    for (int i = 0; i < memWords; i++) begin
      mem[i] = '0;
    end
    lastWrAdr = '0;
    wp = 0;
    case (r.op)
      IN: begin
        emit(enc(IN, 1, 0, 0));
      end
      MOV: begin
        emitLdm(1, r.a);
        emitLdm(2, r.b);
        emit(enc(MOV, 1, 2, 0));
      end
      STD: begin
        emitLdm(1, r.a);
        emitLdm(2, r.b);
        emit(enc(STD, 1, 2, 0));
        emit(enc(LDD, 3, 2, 0));
      end
      PUSH: begin
        emitLdm(1, r.a);
        emit(enc(PUSH, 1, 0, 0));
        emit(enc(POP, 3, 0, 0));
      end
      JZ, JN, JC: begin
        emitLdm(1, r.a);
        emitLdm(2, r.b);
        // SETC and CLRC follow an ADD so they override a known carry
        if (r.pre == SETC || r.pre == CLRC) begin
          emit(enc(ADD, 1, 2, 0));
          emit(enc(r.pre, 0, 0, 0));
        end else begin
          emit(enc(r.pre, 1, 2, 0));
        end
        emitLdm(4, subAddr);
        emit(enc(r.op, 4, 0, 0));
        emitLdm(5, notTaken);
        emit(enc(OUT, 5, 0, 0));
        emitHalt();
        wp = int'(subAddr);
        emitLdm(5, taken);
      end
      CALL: begin
        emitLdm(1, r.a);
        emitLdm(2, r.b);
        emitLdm(4, subAddr);
        emit(enc(CALL, 4, 0, 0));
        emit(enc(OUT, 2, 0, 0));
        emitHalt();
        wp = int'(subAddr);
        emit(enc(OUT, 1, 0, 0));
        emit(enc(RET, 0, 0, 0));
      end
      default: begin
        emitLdm(1, r.a);
        emitLdm(2, r.b);
        emit(enc(r.op, 1, 2, shamt));
      end
    endcase
    if (r.op == STD || r.op == PUSH) begin
      emit(enc(OUT, 3, 0, 0));
    end else if (r.op == JZ || r.op == JN || r.op == JC) begin
      emit(enc(OUT, 5, 0, 0));
    end else if (r.op != CALL) begin
      emit(enc(OUT, 1, 0, 0));
    end
    if (r.op != CALL) begin
      emitHalt();
    end
  endtask

  // outPort loads on the edge that ends the strobe
  task automatic waitForOut(output word_t value, output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    value = '0;
    while (!ok && cycles < waitLimit) begin
      @(negedge clk);
      if (outStrobe === 1'b1) begin
        ok = 1'b1;
      end
      cycles++;
    end
    if (ok) begin
      @(negedge clk);
      value = outPort;
    end else begin
      $display("timeout: no output strobe within %0d cycles", waitLimit);
      errors++;
    end
  endtask

  task automatic runRow(input int idx);
    row_t    r;
    opCode_t op;
    opCode_t pre;
    word_t   got;
    bit      ok;
    int      errBefore;
    r = rows[idx];
    op = r.op;
    pre = r.pre;
    errBefore = errors;
    @(posedge clk);
    #2;
    rst = 1'b1;
    inPort = r.a;
    @(posedge clk);
    #2;
    loadProgram(r);
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    waitForOut(got, ok);
    if (ok && op == CALL) begin
      checkValue("outPort in subroutine", got, r.a);
      waitForOut(got, ok);
    end
    if (ok) begin
      checkValue("outPort", got, r.expected);
    end
    if (op == STD) begin
      checkValue("write address", lastWrAdr, r.b);
      checkValue("memory word", mem[r.b[11:0]], r.a);
    end
    if (op == PUSH) begin
      checkValue("write address", lastWrAdr, stackTop);
      checkValue("stack word", mem[stackTop[11:0]], r.a);
    end
    $display("test %0d %s %s: %s", idx, op.name(), pre.name(),
             (errors == errBefore) ? "ok" : "fail");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wbIn = '0;
    inPort = '0;
    errors = 0;
    busy = 1'b0;
    waitLeft = 0;
    lfsr = 32'd87759;
    lastWrAdr = '0;
    wp = 0;

    addRow(ADD,  NOP,  16'h1234, 16'h4321, 16'h5555);
    addRow(ADD,  NOP,  16'hFFFF, 16'h0002, 16'h0001);
    addRow(SUB,  NOP,  16'h5000, 16'h1234, 16'h3DCC);
    addRow(SUB,  NOP,  16'h0001, 16'h0003, 16'hFFFE);
    addRow(AND,  NOP,  16'hF0F0, 16'h3C3C, 16'h3030);
    addRow(OR,   NOP,  16'hF000, 16'h00A5, 16'hF0A5);
    addRow(NOT,  NOP,  16'h5A0F, 16'h0000, 16'hA5F0);
    addRow(INC,  NOP,  16'h00FF, 16'h0000, 16'h0100);
    addRow(DEC,  NOP,  16'h0000, 16'h0000, 16'hFFFF);
    addRow(SHL,  NOP,  16'h1234, 16'h0004, 16'h2340);
    addRow(SHR,  NOP,  16'h8421, 16'h0003, 16'h1084);
    addRow(IN,   NOP,  16'hBEEF, 16'h0000, 16'hBEEF);
    addRow(MOV,  NOP,  16'h1111, 16'h7E57, 16'h7E57);
    addRow(STD,  NOP,  16'hCAFE, 16'h0800, 16'hCAFE);
    addRow(PUSH, NOP,  16'h0BAD, 16'h0000, 16'h0BAD);
    addRow(JZ,   SUB,  16'h0005, 16'h0005, taken);
    addRow(JZ,   SUB,  16'h0006, 16'h0005, notTaken);
    addRow(JN,   SUB,  16'h0003, 16'h0005, taken);
    addRow(JN,   ADD,  16'h0001, 16'h0001, notTaken);
    addRow(JC,   ADD,  16'hFFFF, 16'h0001, taken);
    addRow(JC,   SETC, 16'h0001, 16'h0001, taken);
    addRow(JC,   CLRC, 16'hFFFF, 16'h0001, notTaken);
    addRow(CALL, NOP,  16'h00C1, 16'h00C2, 16'h00C2);

    for (int i = 0; i < rows.size(); i++) begin
      runRow(i);
    end

    $display("%0d tests, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
isaPkg.sv
busPkg.sv
controlUnit.sv
sequencer.sv
addrCounters.sv
regFile.sv
alu.sv
cpuTop.sv
tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb &&
  ./obj_dir/Vtb | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null || exit 1
